// File: verilog/rvc_pkg.sv
// RV32C decoder shared definitions
package rvc_pkg;

    localparam int INST_W = 16;  // Compressed word
    localparam int XLEN   = 32;
    localparam int REG_W  = 5;
    localparam int ALU_W  = 4;

    typedef logic [INST_W-1:0] inst16_t;
    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_W-1:0]  reg_addr_t;
    typedef logic [ALU_W-1:0]  alu_op_t;
    typedef logic [2:0]        sel_data_t;  // Writeback source
    typedef logic [1:0]        mem_size_t;  // Load/store size

    // Opcode quadrant in inst[1:0]
    localparam logic [1:0] QUAD_C0   = 2'd0;
    localparam logic [1:0] QUAD_C1   = 2'd1;
    localparam logic [1:0] QUAD_C2   = 2'd2;
    localparam logic [1:0] QUAD_FULL = 2'd3;  // 32-bit encoding

    // funct3 in inst[15:13], per quadrant
    localparam logic [2:0] F3_C0_ADDI4SPN = 3'd0;
    localparam logic [2:0] F3_C0_LW       = 3'd2;
    localparam logic [2:0] F3_C0_SW       = 3'd6;

    localparam logic [2:0] F3_C1_ADDI     = 3'd0;  // Also NOP
    localparam logic [2:0] F3_C1_JAL      = 3'd1;
    localparam logic [2:0] F3_C1_LI       = 3'd2;
    localparam logic [2:0] F3_C1_LUI      = 3'd3;  // Shared with ADDI16SP
    localparam logic [2:0] F3_C1_MISC_ALU = 3'd4;
    localparam logic [2:0] F3_C1_J        = 3'd5;
    localparam logic [2:0] F3_C1_BEQZ     = 3'd6;
    localparam logic [2:0] F3_C1_BNEZ     = 3'd7;

    localparam logic [2:0] F3_C2_SLLI     = 3'd0;
    localparam logic [2:0] F3_C2_LWSP     = 3'd2;
    localparam logic [2:0] F3_C2_CR       = 3'd4;  // JR, MV, JALR, ADD
    localparam logic [2:0] F3_C2_SWSP     = 3'd6;

    // funct2 in inst[11:10] of the misc ALU group
    localparam logic [1:0] F2_SRLI  = 2'd0;
    localparam logic [1:0] F2_SRAI  = 2'd1;
    localparam logic [1:0] F2_ANDI  = 2'd2;
    localparam logic [1:0] F2_ARITH = 2'd3;  // CA format

    // ALU operation codes
    localparam alu_op_t ALU_ADD = 4'd1;
    localparam alu_op_t ALU_SUB = 4'd2;
    localparam alu_op_t ALU_AND = 4'd3;
    localparam alu_op_t ALU_OR  = 4'd4;
    localparam alu_op_t ALU_XOR = 4'd5;
    localparam alu_op_t ALU_SLL = 4'd8;
    localparam alu_op_t ALU_SRL = 4'd9;
    localparam alu_op_t ALU_SRA = 4'd10;

    // Writeback sources
    localparam sel_data_t SEL_DATA_PC4 = 3'd0;
    localparam sel_data_t SEL_DATA_ALU = 3'd1;
    localparam sel_data_t SEL_DATA_IMM = 3'd2;
    localparam sel_data_t SEL_DATA_MEM = 3'd3;

    localparam mem_size_t MEM_NONE = 2'd0;
    localparam mem_size_t MEM_WORD = 2'd2;

    // Fixed registers
    localparam reg_addr_t REG_ZERO = 5'd0;
    localparam reg_addr_t REG_RA   = 5'd1;
    localparam reg_addr_t REG_SP   = 5'd2;

    localparam reg_addr_t RVC_REG_BASE = 5'd8;  // x8 for the 3-bit fields

endpackage

// File: verilog/rvc_opcode_decode.sv
// RVC opcode decode
// Register addresses, ALU op and class flags
`timescale 1ns/1ps

module rvc_opcode_decode (
    input  rvc_pkg::inst16_t   i_inst,
    output rvc_pkg::reg_addr_t o_rs1,
    output rvc_pkg::reg_addr_t o_rs2,
    output rvc_pkg::reg_addr_t o_rd,
    output rvc_pkg::alu_op_t   o_alu_op,
    output logic               o_j_type,        // J, JAL
    output logic               o_jr_type,       // JR, JALR
    output logic               o_b_type,        // BEQZ, BNEZ
    output logic               o_r_type,        // Register-register ops
    output logic               o_lui_type,
    output logic               o_load,
    output logic               o_store,
    output logic               o_is_nop,
    output logic               o_spn_imm,       // ADDI4SPN offset
    output logic               o_sp_imm,        // ADDI16SP offset
    output logic               o_lssp_imm,      // LWSP/SWSP offset
    output logic               o_unsigned_imm   // Zero-extend immediate
);
    import rvc_pkg::*;

    logic [1:0] quad;
    logic [2:0] funct3;
    logic       funct4;
    logic [1:0] funct2_hi;
    logic [1:0] funct2_lo;
    reg_addr_t  rd_full;   // Also rs1 for CI/CR
    reg_addr_t  rs2_full;
    reg_addr_t  rs1_c;     // x8..x15
    reg_addr_t  rs2_c;

    assign quad      = i_inst[1:0];
    assign funct3    = i_inst[15:13];
    assign funct4    = i_inst[12];
    assign funct2_hi = i_inst[11:10];
    assign funct2_lo = i_inst[6:5];
    assign rd_full   = i_inst[11:7];
    assign rs2_full  = i_inst[6:2];
    assign rs1_c     = RVC_REG_BASE + reg_addr_t'(i_inst[9:7]);
    assign rs2_c     = RVC_REG_BASE + reg_addr_t'(i_inst[4:2]);

    always_comb begin
        // Defaults, which unimplemented words keep
        o_rs1          = REG_ZERO;
        o_rs2          = REG_ZERO;
        o_rd           = REG_ZERO;
        o_alu_op       = ALU_ADD;
        o_j_type       = 1'b0;
        o_jr_type      = 1'b0;
        o_b_type       = 1'b0;
        o_r_type       = 1'b0;
        o_lui_type     = 1'b0;
        o_load         = 1'b0;
        o_store        = 1'b0;
        o_is_nop       = 1'b0;
        o_spn_imm      = 1'b0;
        o_sp_imm       = 1'b0;
        o_lssp_imm     = 1'b0;
        o_unsigned_imm = 1'b0;

        case (quad)
            QUAD_C0: begin
                case (funct3)
                    F3_C0_ADDI4SPN: begin  // addi rd', x2, nzuimm
                        o_rd           = rs2_c;
                        o_rs1          = REG_SP;
                        o_spn_imm      = 1'b1;
                        o_unsigned_imm = 1'b1;
                    end
                    F3_C0_LW: begin
                        o_rd           = rs2_c;
                        o_rs1          = rs1_c;
                        o_load         = 1'b1;
                        o_unsigned_imm = 1'b1;
                    end
                    F3_C0_SW: begin
                        o_rs1          = rs1_c;
                        o_rs2          = rs2_c;
                        o_store        = 1'b1;
                        o_unsigned_imm = 1'b1;
                    end
                    default: ;  // Reserved or FP
                endcase
            end
            QUAD_C1: begin
                case (funct3)
                    F3_C1_ADDI: begin
                        o_rd     = rd_full;
                        o_rs1    = rd_full;
                        o_is_nop = (rd_full == REG_ZERO);
                    end
                    F3_C1_JAL: begin
                        o_rd     = REG_RA;  // Link register
                        o_j_type = 1'b1;
                    end
                    F3_C1_J: o_j_type = 1'b1;   // rd stays x0
                    F3_C1_LI: o_rd = rd_full;   // addi rd, x0, imm
                    F3_C1_LUI: begin
                        if (rd_full == REG_SP) begin
                            // ADDI16SP
                            o_rd     = REG_SP;
                            o_rs1    = REG_SP;
                            o_sp_imm = 1'b1;
                        end else begin
                            o_rd       = rd_full;
                            o_lui_type = 1'b1;
                        end
                    end
                    F3_C1_MISC_ALU: begin
                        o_rd  = rs1_c;
                        o_rs1 = rs1_c;
                        case (funct2_hi)
                            F2_SRLI: begin
                                o_alu_op       = ALU_SRL;
                                o_unsigned_imm = 1'b1;  // shamt
                            end
                            F2_SRAI: begin
                                o_alu_op       = ALU_SRA;
                                o_unsigned_imm = 1'b1;
                            end
                            F2_ANDI: o_alu_op = ALU_AND;
                            default: begin  // F2_ARITH
                                if (!funct4) begin
                                    o_r_type = 1'b1;
                                    o_rs2    = rs2_c;
                                    case (funct2_lo)
                                        2'd0:    o_alu_op = ALU_SUB;
                                        2'd1:    o_alu_op = ALU_XOR;
                                        2'd2:    o_alu_op = ALU_OR;
                                        default: o_alu_op = ALU_AND;
                                    endcase
                                end else begin
                                    // RV64 only, back to defaults
                                    o_rd  = REG_ZERO;
                                    o_rs1 = REG_ZERO;
                                end
                            end
                        endcase
                    end
                    default: begin  // BEQZ, BNEZ compare against x0
                        o_rs1    = rs1_c;
                        o_b_type = 1'b1;
                        o_alu_op = ALU_SUB;
                    end
                endcase
            end
            QUAD_C2: begin
                case (funct3)
                    F3_C2_SLLI: begin
                        o_rd     = rd_full;
                        o_rs1    = rd_full;
                        o_alu_op = ALU_SLL;
                    end
                    F3_C2_LWSP: begin
                        o_rd           = rd_full;
                        o_rs1          = REG_SP;
                        o_load         = 1'b1;
                        o_lssp_imm     = 1'b1;
                        o_unsigned_imm = 1'b1;
                    end
                    F3_C2_SWSP: begin
                        o_rs1          = REG_SP;
                        o_rs2          = rs2_full;
                        o_store        = 1'b1;
                        o_lssp_imm     = 1'b1;
                        o_unsigned_imm = 1'b1;
                    end
                    F3_C2_CR: begin
                        if (rs2_full != REG_ZERO) begin
                            // MV with funct4 low, ADD with it high
                            o_rd     = rd_full;
                            o_rs1    = funct4 ? rd_full : REG_ZERO;
                            o_rs2    = rs2_full;
                            o_r_type = 1'b1;
                        end else if (!funct4 || rd_full != REG_ZERO) begin
                            o_jr_type = 1'b1;  // JR or JALR
                            o_rs1     = rd_full;
                            o_rd      = funct4 ? REG_RA : REG_ZERO;
                        end
                        // EBREAK falls through with defaults
                    end
                    default: ;
                endcase
            end
            default: ;  // QUAD_FULL, not compressed
        endcase
    end

endmodule

// File: verilog/rvc_imm_gen.sv
// RVC immediate and jump offset generation
`timescale 1ns/1ps

module rvc_imm_gen (
    input  rvc_pkg::inst16_t i_inst,
    input  logic             i_j_type,
    input  logic             i_lui_type,
    input  logic             i_load,
    input  logic             i_store,
    input  logic             i_spn_imm,
    input  logic             i_sp_imm,
    input  logic             i_lssp_imm,
    input  logic             i_unsigned_imm,
    output rvc_pkg::word_t   o_imm,  // Extended immediate
    output rvc_pkg::word_t   o_jt    // Jump or branch offset
);

    logic sign;

    assign sign = i_inst[12] & ~i_unsigned_imm;

    always_comb begin
        if (i_lui_type) begin
            // nzimm[17:12]
            o_imm = {{14{sign}}, i_inst[12], i_inst[6:2], 12'd0};
        end else if (i_sp_imm) begin
            // nzimm[9|4|6|8:7|5]
            o_imm = {{22{sign}}, i_inst[12], i_inst[4:3], i_inst[5], i_inst[2],
                     i_inst[6], 4'd0};
        end else if (i_spn_imm) begin
            // nzuimm[5:4|9:6|2|3]
            o_imm = {22'd0, i_inst[10:7], i_inst[12:11], i_inst[5], i_inst[6], 2'd0};
        end else if (i_lssp_imm && i_load) begin
            o_imm = {24'd0, i_inst[3:2], i_inst[12], i_inst[6:4], 2'd0};  // LWSP
        end else if (i_lssp_imm && i_store) begin
            o_imm = {24'd0, i_inst[8:7], i_inst[12:9], 2'd0};              // SWSP
        end else if (i_load || i_store) begin
            // LW/SW uimm[5:3|2|6]
            o_imm = {25'd0, i_inst[5], i_inst[12:10], i_inst[6], 2'd0};
        end else begin
            // CI form, zero-extended for shifts
            o_imm = {{26{sign}}, i_inst[12], i_inst[6:2]};
        end
    end

    always_comb begin
        if (i_j_type) begin
            // CJ offset[11|4|9:8|10|6|7|3:1|5]
            o_jt = {{20{i_inst[12]}}, i_inst[12], i_inst[8], i_inst[10:9], i_inst[6],
                    i_inst[7], i_inst[2], i_inst[11], i_inst[5:3], 1'b0};
        end else begin
            // CB offset[8|4:3] and [7:6|2:1|5]
            o_jt = {{23{i_inst[12]}}, i_inst[12], i_inst[6:5], i_inst[2],
                    i_inst[11:10], i_inst[4:3], 1'b0};
        end
    end

endmodule

// File: verilog/rvc_ctrl_gen.sv
// RVC pipeline control generation
`timescale 1ns/1ps

module rvc_ctrl_gen (
    input  rvc_pkg::inst16_t   i_inst,
    input  rvc_pkg::reg_addr_t i_rs1,
    input  rvc_pkg::reg_addr_t i_rs2,
    input  logic               i_j_type,
    input  logic               i_jr_type,
    input  logic               i_b_type,
    input  logic               i_r_type,
    input  logic               i_lui_type,
    input  logic               i_load,
    input  logic               i_store,
    output logic               o_is_compressed,
    output logic               o_sel_op_a,     // Register A, else immediate
    output logic               o_sel_op_b,     // Immediate, else register B
    output logic               o_sel_op_br,    // Register base for JR/JALR
    output logic               o_sel_pc,       // Redirect from ID
    output logic               o_wr_en,
    output logic               o_is_jump,
    output logic               o_is_btype,
    output logic               o_is_ltype,
    output logic               o_is_stype,
    output logic               o_use_a,
    output logic               o_use_b,
    output logic [1:0]         o_btype,        // {BEQZ, BNEZ}
    output rvc_pkg::sel_data_t o_sel_data,
    output rvc_pkg::mem_size_t o_dm_select,
    output rvc_pkg::mem_size_t o_store_select
);
    import rvc_pkg::*;

    assign o_is_compressed = (i_inst[1:0] != QUAD_FULL);

    assign o_sel_op_a  = ~(i_lui_type | i_j_type);
    assign o_sel_op_b  = ~(i_r_type | i_b_type);
    assign o_sel_op_br = i_jr_type;
    assign o_sel_pc    = i_j_type | i_jr_type;
    assign o_is_jump   = i_j_type | i_jr_type;

    // No writeback for stores, branches and the illegal all-zero word
    assign o_wr_en = ~(i_store | i_b_type | (i_inst == 16'd0));

    assign o_is_btype = i_b_type;
    assign o_is_ltype = i_load;
    assign o_is_stype = i_store;
    assign o_btype    = i_b_type ? {~i_inst[13], i_inst[13]} : 2'b00;  // funct3[0]

    // Hazard check only needs nonzero sources
    assign o_use_a = (i_rs1 != REG_ZERO);
    assign o_use_b = (i_rs2 != REG_ZERO);

    always_comb begin
        if (i_j_type || i_jr_type) begin
            o_sel_data = SEL_DATA_PC4;  // Link value
        end else if (i_lui_type) begin
            o_sel_data = SEL_DATA_IMM;
        end else if (i_load) begin
            o_sel_data = SEL_DATA_MEM;
        end else begin
            o_sel_data = SEL_DATA_ALU;
        end
    end

    assign o_dm_select    = i_load  ? MEM_WORD : MEM_NONE;
    assign o_store_select = i_store ? MEM_WORD : MEM_NONE;

endmodule

// File: verilog/rvc_decoder.sv
// RV32C compressed instruction decoder
`timescale 1ns/1ps

module rvc_decoder (
    input  rvc_pkg::inst16_t   i_inst,           // Low half of the ID word
    output rvc_pkg::reg_addr_t o_rs1,
    output rvc_pkg::reg_addr_t o_rs2,
    output rvc_pkg::reg_addr_t o_rd,
    output rvc_pkg::alu_op_t   o_alu_op,
    output logic               o_is_nop,
    output rvc_pkg::word_t     o_imm,
    output rvc_pkg::word_t     o_jt,
    output logic               o_is_compressed,
    output logic               o_sel_op_a,
    output logic               o_sel_op_b,
    output logic               o_sel_op_br,
    output logic               o_sel_pc,
    output logic               o_wr_en,
    output logic               o_is_jump,
    output logic               o_is_btype,
    output logic               o_is_ltype,
    output logic               o_is_stype,
    output logic               o_use_a,
    output logic               o_use_b,
    output logic [1:0]         o_btype,
    output rvc_pkg::sel_data_t o_sel_data,
    output rvc_pkg::mem_size_t o_dm_select,
    output rvc_pkg::mem_size_t o_store_select
);

    // Class flags
    logic j_type;
    logic jr_type;
    logic b_type;
    logic r_type;
    logic lui_type;
    logic load_inst;
    logic store_inst;
    // Immediate format
    logic spn_imm;
    logic sp_imm;
    logic lssp_imm;
    logic unsigned_imm;

    rvc_opcode_decode u_opcode_decode (
        .i_inst         (i_inst),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_rd           (o_rd),
        .o_alu_op       (o_alu_op),
        .o_j_type       (j_type),
        .o_jr_type      (jr_type),
        .o_b_type       (b_type),
        .o_r_type       (r_type),
        .o_lui_type     (lui_type),
        .o_load         (load_inst),
        .o_store        (store_inst),
        .o_is_nop       (o_is_nop),
        .o_spn_imm      (spn_imm),
        .o_sp_imm       (sp_imm),
        .o_lssp_imm     (lssp_imm),
        .o_unsigned_imm (unsigned_imm)
    );

    rvc_imm_gen u_imm_gen (
        .i_inst         (i_inst),
        .i_j_type       (j_type),
        .i_lui_type     (lui_type),
        .i_load         (load_inst),
        .i_store        (store_inst),
        .i_spn_imm      (spn_imm),
        .i_sp_imm       (sp_imm),
        .i_lssp_imm     (lssp_imm),
        .i_unsigned_imm (unsigned_imm),
        .o_imm          (o_imm),
        .o_jt           (o_jt)
    );

    rvc_ctrl_gen u_ctrl_gen (
        .i_inst          (i_inst),
        .i_rs1           (o_rs1),
        .i_rs2           (o_rs2),
        .i_j_type        (j_type),
        .i_jr_type       (jr_type),
        .i_b_type        (b_type),
        .i_r_type        (r_type),
        .i_lui_type      (lui_type),
        .i_load          (load_inst),
        .i_store         (store_inst),
        .o_is_compressed (o_is_compressed),
        .o_sel_op_a      (o_sel_op_a),
        .o_sel_op_b      (o_sel_op_b),
        .o_sel_op_br     (o_sel_op_br),
        .o_sel_pc        (o_sel_pc),
        .o_wr_en         (o_wr_en),
        .o_is_jump       (o_is_jump),
        .o_is_btype      (o_is_btype),
        .o_is_ltype      (o_is_ltype),
        .o_is_stype      (o_is_stype),
        .o_use_a         (o_use_a),
        .o_use_b         (o_use_b),
        .o_btype         (o_btype),
        .o_sel_data      (o_sel_data),
        .o_dm_select     (o_dm_select),
        .o_store_select  (o_store_select)
    );

endmodule

// File: include/rvc_tb_expect.svh
// Expected RVC decode from the expansion rules
`ifndef RVC_TB_EXPECT_SVH
`define RVC_TB_EXPECT_SVH

typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    alu_op_t    alu;
    word_t      imm;
    logic       imm_chk;   // Immediate defined for this word
    word_t      jt;
    logic       jump;      // J, JAL, JR, JALR
    logic       jr;
    logic       rtype;     // Second operand from a register
    logic       branch;
    logic [1:0] btype;
    logic       lui;
    logic       load;
    logic       store;
    logic       nop;
    logic       wr_en;
    sel_data_t  sel_data;
} expect_t;

function automatic expect_t expect_decode(input inst16_t w);
    expect_t   e;
    logic      known;
    reg_addr_t r_hi;
    reg_addr_t r_lo;
    reg_addr_t rp_hi;
    reg_addr_t rp_lo;
    word_t     ci;
    word_t     cb;
    e     = '0;
    known = 1'b1;
    r_hi  = w[11:7];
    r_lo  = w[6:2];
    rp_hi = 5'd8 + {2'b00, w[9:7]};  // x8..x15
    rp_lo = 5'd8 + {2'b00, w[4:2]};
    ci    = {{26{w[12]}}, w[12], w[6:2]};
    cb    = {{23{w[12]}}, w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0};
    e.alu = ALU_ADD;
    e.jt  = cb;  // CB offset unless a jump
    case ({w[1:0], w[15:13]})
        5'b00_000: begin  // ADDI4SPN
            e.rd  = rp_lo;
            e.rs1 = REG_SP;
            e.imm = {22'd0, w[10:7], w[12:11], w[5], w[6], 2'b00};
        end
        5'b00_010, 5'b00_110: begin  // LW, SW
            e.rs1   = rp_hi;
            e.rd    = w[15] ? REG_ZERO : rp_lo;
            e.rs2   = w[15] ? rp_lo : REG_ZERO;
            e.load  = ~w[15];
            e.store = w[15];
            e.imm   = {25'd0, w[5], w[12:10], w[6], 2'b00};
        end
        5'b01_000, 5'b01_010: begin  // ADDI, NOP, LI
            e.rd  = r_hi;
            e.rs1 = w[14] ? REG_ZERO : r_hi;  // LI reads x0
            e.imm = ci;
            e.nop = ~w[14] && (r_hi == REG_ZERO);
        end
        5'b01_001, 5'b01_101: begin  // JAL, J
            e.rd   = w[15] ? REG_ZERO : REG_RA;
            e.jump = 1'b1;
            e.jt   = {{20{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11],
                      w[5:3], 1'b0};
        end
        5'b01_011: begin
            if (r_hi == REG_SP) begin  // ADDI16SP
                e.rd  = REG_SP;
                e.rs1 = REG_SP;
                e.imm = {{22{w[12]}}, w[12], w[4:3], w[5], w[2], w[6], 4'd0};
            end else begin
                e.rd  = r_hi;
                e.lui = 1'b1;
                e.imm = {{14{w[12]}}, w[12], w[6:2], 12'd0};
            end
        end
        5'b01_100: begin
            e.rd  = rp_hi;
            e.rs1 = rp_hi;
            if (w[11:10] != 2'b11) begin  // SRLI, SRAI, ANDI
                e.alu = (w[11:10] == 2'b00) ? ALU_SRL :
                        (w[11:10] == 2'b01) ? ALU_SRA : ALU_AND;
                e.imm = w[11] ? ci : {26'd0, w[12], w[6:2]};  // shamt unsigned
            end else if (!w[12]) begin
                e.rs2   = rp_lo;
                e.rtype = 1'b1;
                case (w[6:5])
                    2'b00:   e.alu = ALU_SUB;
                    2'b01:   e.alu = ALU_XOR;
                    2'b10:   e.alu = ALU_OR;
                    default: e.alu = ALU_AND;
                endcase
            end else begin
                known = 1'b0;  // RV64 forms
            end
        end
        5'b01_110, 5'b01_111: begin  // BEQZ, BNEZ
            e.rs1    = rp_hi;
            e.alu    = ALU_SUB;
            e.branch = 1'b1;
            e.btype  = w[13] ? 2'b01 : 2'b10;
        end
        5'b10_000: begin  // SLLI
            e.rd  = r_hi;
            e.rs1 = r_hi;
            e.alu = ALU_SLL;
            e.imm = ci;
        end
        5'b10_010: begin  // LWSP
            e.rd   = r_hi;
            e.rs1  = REG_SP;
            e.load = 1'b1;
            e.imm  = {24'd0, w[3:2], w[12], w[6:4], 2'b00};
        end
        5'b10_110: begin  // SWSP
            e.rs1   = REG_SP;
            e.rs2   = r_lo;
            e.store = 1'b1;
            e.imm   = {24'd0, w[8:7], w[12:9], 2'b00};
        end
        5'b10_100: begin
            if (r_lo != REG_ZERO) begin  // MV, ADD
                e.rd    = r_hi;
                e.rs1   = w[12] ? r_hi : REG_ZERO;
                e.rs2   = r_lo;
                e.rtype = 1'b1;
            end else if (!w[12] || r_hi != REG_ZERO) begin  // JR, JALR
                e.rs1  = r_hi;
                e.rd   = w[12] ? REG_RA : REG_ZERO;
                e.jump = 1'b1;
                e.jr   = 1'b1;
            end else begin
                known = 1'b0;  // EBREAK
            end
        end
        default: known = 1'b0;
    endcase
    if (!known) begin
        e     = '0;
        e.alu = ALU_ADD;
        e.jt  = cb;
    end
    e.imm_chk  = known & ~(e.jump | e.branch | e.rtype);
    e.wr_en    = ~(e.store | e.branch) & (w != 16'd0);
    e.sel_data = e.jump ? SEL_DATA_PC4 : e.lui ? SEL_DATA_IMM :
                 e.load ? SEL_DATA_MEM : SEL_DATA_ALU;
    return e;
endfunction

`endif

// File: verification/tb_rvc_decoder.sv
// RVC decoder testbench
`timescale 1ns/1ps

module tb_rvc_decoder;
    import rvc_pkg::*;

    `include "rvc_tb_expect.svh"

    localparam int N_DIRECTED = 32;
    localparam int N_RANDOM   = 2000;
    localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM + 20) * 40;

    logic      clk = 1'b0;
    logic      i_arst_n;
    inst16_t   inst;
    reg_addr_t o_rs1;
    reg_addr_t o_rs2;
    reg_addr_t o_rd;
    alu_op_t   o_alu_op;
    logic      o_is_nop;
    word_t     o_imm;
    word_t     o_jt;
    logic      o_is_compressed;
    logic      o_sel_op_a;
    logic      o_sel_op_b;
    logic      o_sel_op_br;
    logic      o_sel_pc;
    logic      o_wr_en;
    logic      o_is_jump;
    logic      o_is_btype;
    logic      o_is_ltype;
    logic      o_is_stype;
    logic      o_use_a;
    logic      o_use_b;
    logic [1:0] o_btype;
    sel_data_t o_sel_data;
    mem_size_t o_dm_select;
    mem_size_t o_store_select;
    expect_t   expd;
    integer    seed;

    // One word per instruction, then reserved and 32-bit words
    inst16_t directed_words [N_DIRECTED] = '{
        16'h0000, 16'h1FFC, 16'h5A5C, 16'hC3F8, 16'h0001, 16'h117D, 16'h3FF5, 16'h5535,
        16'h7F85, 16'h717D, 16'h8385, 16'h9785, 16'h9B7D, 16'h8C05, 16'h8EA9, 16'h8FD1,
        16'h8D7D, 16'h9C05, 16'hB0F9, 16'hD8F1, 16'hE4A5, 16'h1FFE, 16'h5F7A, 16'hCEA6,
        16'h8F82, 16'h85AA, 16'h9302, 16'h9A3E, 16'h9002, 16'h0513, 16'hFFFF, 16'h2000
    };

    rvc_decoder i_dut (
        .i_inst          (inst),
        .o_rs1           (o_rs1),
        .o_rs2           (o_rs2),
        .o_rd            (o_rd),
        .o_alu_op        (o_alu_op),
        .o_is_nop        (o_is_nop),
        .o_imm           (o_imm),
        .o_jt            (o_jt),
        .o_is_compressed (o_is_compressed),
        .o_sel_op_a      (o_sel_op_a),
        .o_sel_op_b      (o_sel_op_b),
        .o_sel_op_br     (o_sel_op_br),
        .o_sel_pc        (o_sel_pc),
        .o_wr_en         (o_wr_en),
        .o_is_jump       (o_is_jump),
        .o_is_btype      (o_is_btype),
        .o_is_ltype      (o_is_ltype),
        .o_is_stype      (o_is_stype),
        .o_use_a         (o_use_a),
        .o_use_b         (o_use_b),
        .o_btype         (o_btype),
        .o_sel_data      (o_sel_data),
        .o_dm_select     (o_dm_select),
        .o_store_select  (o_store_select)
    );

    always #20 clk = ~clk;  // 40 ns period

    always_comb expd = expect_decode(inst);

    // Inputs only move on the falling edge, so inst is stable here
    task automatic flag_mismatch(input string what);
        $display("** Error at %0t: %s wrong for inst %h", $time, what, inst);
        $display("Test failures found");
        $fatal(1, "Decoder output check failed");
    endtask

    a_compressed: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_is_compressed != (&inst[1:0])) else flag_mismatch("o_is_compressed");
    a_rs1: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_rs1 == expd.rs1) else flag_mismatch("o_rs1");
    a_rs2: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_rs2 == expd.rs2) else flag_mismatch("o_rs2");
    a_rd: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_rd == expd.rd) else flag_mismatch("o_rd");
    a_alu: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_alu_op == expd.alu) else flag_mismatch("o_alu_op");
    a_imm: assert property (@(posedge clk) disable iff (!i_arst_n)
        expd.imm_chk |-> o_imm == expd.imm) else flag_mismatch("o_imm");
    a_jt: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_jt == expd.jt) else flag_mismatch("o_jt");
    a_jump: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_is_jump == expd.jump && o_sel_pc == expd.jump) else flag_mismatch("jump flags");
    a_op_a: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_sel_op_a == !(expd.lui || (expd.jump && !expd.jr)))  // PC or zero base
        else flag_mismatch("o_sel_op_a");
    a_op_br: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_sel_op_br == expd.jr) else flag_mismatch("o_sel_op_br");
    a_op_b: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_sel_op_b == !(expd.rtype || expd.branch)) else flag_mismatch("o_sel_op_b");
    a_branch: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_is_btype == expd.branch && o_btype == expd.btype) else flag_mismatch("branch flags");
    a_load: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_is_ltype == expd.load && o_dm_select == (expd.load ? MEM_WORD : MEM_NONE))
        else flag_mismatch("load flags");
    a_store: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_is_stype == expd.store && o_store_select == (expd.store ? MEM_WORD : MEM_NONE))
        else flag_mismatch("store flags");
    a_nop: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_is_nop == expd.nop) else flag_mismatch("o_is_nop");
    a_wr_en: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wr_en == expd.wr_en) else flag_mismatch("o_wr_en");
    a_sel_data: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_sel_data == expd.sel_data) else flag_mismatch("o_sel_data");
    a_use: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_use_a == (expd.rs1 != REG_ZERO) && o_use_b == (expd.rs2 != REG_ZERO))
        else flag_mismatch("register use flags");

    initial begin
        seed     = 32'h9388_01c5;
        i_arst_n = 1'b0;
        inst     = 16'h0001;  // NOP during reset
        repeat (8) @(negedge clk);
        i_arst_n = 1'b1;
        foreach (directed_words[k]) begin
            inst = directed_words[k];
            @(negedge clk);
        end
        repeat (N_RANDOM) begin
            inst = inst16_t'($random(seed));
            @(negedge clk);
        end
        $display("All tests passed!");
        $finish;
    end

    // Watchdog sized from reset, word count and margin
    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("Run timed out after %0d ns before all words were decoded", TIMEOUT_NS);
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: files.f
+incdir+include
verilog/rvc_pkg.sv
verilog/rvc_opcode_decode.sv
verilog/rvc_imm_gen.sv
verilog/rvc_ctrl_gen.sv
verilog/rvc_decoder.sv
verification/tb_rvc_decoder.sv
